// ==== all.f ====
fetch_pkg.sv
l15_resp_decoder.sv
l15_fetch_fsm.sv
fetch_pc_sequencer.sv
fetch_instr_out.sv
fetch_frontend.sv
tb_fetch_frontend.sv

// ==== fetch_frontend.sv ====
`timescale 1ns/1ps

module fetch_frontend
	import fetch_pkg::*;
#(
	parameter addr_t RESET_PC = 32'h4000_0000
)
(
	input  logic         clk,
	input  logic         nrst,
	input  logic         stall,
	input  logic         nostall,
	input  logic [1:0]   killnum,
	input  logic [1:0]   pcsel,
	input  addr_t        target,
	input  logic         exception_pending,
	input  addr_t        epc,
	output logic         instruction_addr_misaligned2,
	output addr_t        pc2,
	output instr_t       instr2,
	output logic         discardwire,
	// l1.5 request
	output logic [4:0]   transducer_l15_rqtype,
	output logic [2:0]   transducer_l15_size,
	output addr_t        transducer_l15_address,
	output l15_data_t    transducer_l15_data,
	output logic         transducer_l15_val,
	input  logic         l15_transducer_ack,
	input  logic         l15_transducer_header_ack,
	// l1.5 response
	input  logic         l15_transducer_val,
	input  l15_data_t    l15_transducer_data_0,
	input  l15_data_t    l15_transducer_data_1,
	input  l15_rtype_t   l15_transducer_returntype,
	output logic         transducer_l15_req_ack,
	output fetch_state_e state_reg
);

	l15_resp_s  resp;
	resp_info_s info;
	fetch_ctl_s ctl;
	logic       req_fire;
	logic       resp_fire;
	logic [1:0] word_sel;

	assign resp = '{val: l15_transducer_val, rtype: l15_transducer_returntype,
		data_0: l15_transducer_data_0, data_1: l15_transducer_data_1};
	assign transducer_l15_data = '0;	// fetch never writes

	l15_resp_decoder i_dec (.clk(clk), .nrst(nrst), .resp(resp), .word_sel(word_sel),
		.info(info));

	l15_fetch_fsm #(.RESET_PC(RESET_PC)) i_fsm (.clk(clk), .nrst(nrst), .info(info),
		.pc(ctl.pc), .target(target), .pcsel(pcsel), .exception_pending(exception_pending),
		.epc(epc), .header_ack(l15_transducer_header_ack), .ack(l15_transducer_ack),
		.l15_val(transducer_l15_val), .l15_rqtype(transducer_l15_rqtype),
		.l15_size(transducer_l15_size), .l15_address(transducer_l15_address),
		.req_ack(transducer_l15_req_ack), .state(state_reg), .req_fire(req_fire),
		.resp_fire(resp_fire), .word_sel(word_sel));

	fetch_pc_sequencer #(.RESET_PC(RESET_PC)) i_seq (.clk(clk), .nrst(nrst),
		.state(state_reg), .req_fire(req_fire), .resp_fire(resp_fire), .pcsel(pcsel),
		.target(target), .exception_pending(exception_pending), .epc(epc), .stall(stall),
		.nostall(nostall), .killnum(killnum), .wake_up(info.wake_up), .ctl(ctl));

	fetch_instr_out i_out (.info(info), .ctl(ctl), .resp_fire(resp_fire),
		.state(state_reg), .stall(stall), .nostall(nostall), .killnum(killnum),
		.instr2(instr2), .pc2(pc2),
		.instruction_addr_misaligned2(instruction_addr_misaligned2),
		.discardwire(discardwire));

endmodule

// ==== fetch_instr_out.sv ====
`timescale 1ns/1ps

module fetch_instr_out
	import fetch_pkg::*;
(
	input  resp_info_s   info,
	input  fetch_ctl_s   ctl,
	input  logic         resp_fire,
	input  fetch_state_e state,
	input  logic         stall,
	input  logic         nostall,
	input  logic [1:0]   killnum,
	output instr_t       instr2,
	output addr_t        pc2,
	output logic         instruction_addr_misaligned2,
	output logic         discardwire
);

	logic deliver;
	logic discard;
	logic kill;

	// fill is only meaningful in the response phase
	assign deliver = resp_fire && (state == S_RESP);

	// pending discard or one being raised this cycle
	assign discard = ctl.discard_q || (stall && nostall);

	assign kill = ctl.kill_instr
		|| (killnum == 2'd1)
		|| discard
		|| stall;

	// no-op whenever the cache is busy or the word is unwanted
	always_comb
	begin
		if (deliver && !kill)
			instr2 = info.instr;
		else
			instr2 = NOP_INSTR;
	end

	assign pc2 = ctl.pc2;
	assign instruction_addr_misaligned2 = ctl.misaligned2;
	assign discardwire = ctl.discard_q;

endmodule

// ==== fetch_pc_sequencer.sv ====
`timescale 1ns/1ps

module fetch_pc_sequencer
	import fetch_pkg::*;
#(
	parameter addr_t RESET_PC = 32'h4000_0000
)
(
	input  logic         clk,
	input  logic         nrst,
	input  fetch_state_e state,
	input  logic         req_fire,
	input  logic         resp_fire,
	input  logic [1:0]   pcsel,
	input  addr_t        target,
	input  logic         exception_pending,
	input  addr_t        epc,
	input  logic         stall,
	input  logic         nostall,
	input  logic [1:0]   killnum,
	input  logic         wake_up,
	output fetch_ctl_s   ctl
);

	addr_t pc_q;
	addr_t pc2_q;
	logic  mis2_q;
	addr_t tsave_q;		// target seen while a fetch was busy
	logic  pend_q;
	logic  kill_after_q;
	logic  discard_q;

	addr_t npc;
	addr_t req_addr;
	logic  discard_set;
	logic  advance;
	logic  capture;

	assign discard_set = stall && nostall;
	// fill ends normally, pipe moves on
	assign advance = resp_fire && !stall && !discard_q;
	assign capture = (pcsel == 2'd2) && (state != S_REQ) && !resp_fire;

	// next pc once a fill is done
	always_comb
	begin
		if (exception_pending)
			npc = epc;
		else if (pcsel == 2'd1)
			npc = RESET_PC;
		else if (pcsel == 2'd2)
			npc = target;
		else if (pend_q)
			npc = tsave_q;
		else
			npc = pc_q + 32'd4;
	end

	// same pick as the request address, plus the late redirect
	always_comb
	begin
		if (exception_pending)
			req_addr = epc;
		else if (pcsel == 2'd2)
			req_addr = target;
		else if (kill_after_q)
			req_addr = tsave_q;
		else
			req_addr = pc_q;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pc_q   <= RESET_PC;
			pc2_q  <= RESET_PC;
			mis2_q <= 1'b0;
		end
		else if (!wake_up)
		begin
			pc_q   <= RESET_PC;
			pc2_q  <= RESET_PC;
			mis2_q <= 1'b0;
		end
		else if (discard_set || (resp_fire && discard_q))
		begin
			pc_q <= pc2_q;		// refetch what decode dropped
		end
		else if (stall)
		begin
			pc_q  <= pc_q;
			pc2_q <= pc2_q;
		end
		else if (advance)
		begin
			pc_q   <= npc;
			pc2_q  <= pc_q;
			mis2_q <= pc_q[1] & pc_q[0];
		end
		else if (req_fire)
		begin
			pc_q   <= req_addr;
			pc2_q  <= req_addr;
			mis2_q <= req_addr[1] & req_addr[0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			tsave_q <= target;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pend_q       <= 1'b0;
			kill_after_q <= 1'b0;
			discard_q    <= 1'b0;
		end
		else
		begin
			if (advance)
				pend_q <= 1'b0;		// consumed by npc
			else if (capture)
				pend_q <= 1'b1;

			// kill from decode while a branch is waiting to be taken
			if (req_fire)
				kill_after_q <= 1'b0;
			else if ((killnum != 2'd0) && pend_q && (state == S_RESP))
				kill_after_q <= 1'b1;

			if (discard_set)
				discard_q <= 1'b1;
			else if (resp_fire)
				discard_q <= 1'b0;
		end
	end

	always_comb
	begin
		ctl.kill_instr  = kill_after_q;
		ctl.discard_q   = discard_q;
		ctl.pc          = pc_q;
		ctl.pc2         = pc2_q;
		ctl.misaligned2 = mis2_q;
	end

endmodule

// ==== fetch_pkg.sv ====
package fetch_pkg;

	// widths that carry a meaning
	typedef logic [31:0] addr_t;
	typedef logic [31:0] instr_t;
	typedef logic [63:0] l15_data_t;
	typedef logic [3:0]  l15_rtype_t;

	// l1.5 return types seen by the fetch path
	localparam l15_rtype_t RT_LOAD_RET  = 4'b0000;
	localparam l15_rtype_t RT_IFILL_RET = 4'b0001;
	localparam l15_rtype_t RT_INV_RET   = 4'b0011;
	localparam l15_rtype_t RT_ST_ACK    = 4'b0100;
	localparam l15_rtype_t RT_INT_RET   = 4'b0111;	// wake-up packet

	localparam instr_t NOP_INSTR = 32'h0000_0033;	// add x0, x0, x0

	// request channel codes
	localparam logic [4:0] RQ_IFILL    = 5'd0;
	localparam logic [2:0] RQ_SIZE_16B = 3'b111;	// one full line

	// request machine, S_REQ doubles as idle
	typedef enum logic [1:0]
	{
		S_REQ      = 2'd0,
		S_WAIT_ACK = 2'd1,
		S_RESP     = 2'd2
	} fetch_state_e;

	// raw l1.5 response channel
	typedef struct packed
	{
		logic       val;
		l15_rtype_t rtype;
		l15_data_t  data_0;
		l15_data_t  data_1;
	} l15_resp_s;

	// decoded response
	typedef struct packed
	{
		logic   wake_up;	// core may fetch
		logic   fill_val;	// fetch return present
		logic   other_val;	// non-fetch return, ack and drop
		instr_t instr;		// selected word in instruction order
	} resp_info_s;

	// pc pipe state from the sequencer
	typedef struct packed
	{
		logic  kill_instr;
		logic  discard_q;
		addr_t pc;
		addr_t pc2;
		logic  misaligned2;
	} fetch_ctl_s;

endpackage

// ==== l15_fetch_fsm.sv ====
`timescale 1ns/1ps

module l15_fetch_fsm
	import fetch_pkg::*;
#(
	parameter addr_t RESET_PC = 32'h4000_0000
)
(
	input  logic         clk,
	input  logic         nrst,
	input  resp_info_s   info,
	input  addr_t        pc,
	input  addr_t        target,
	input  logic [1:0]   pcsel,
	input  logic         exception_pending,
	input  addr_t        epc,
	input  logic         header_ack,
	input  logic         ack,
	output logic         l15_val,
	output logic [4:0]   l15_rqtype,
	output logic [2:0]   l15_size,
	output addr_t        l15_address,
	output logic         req_ack,
	output fetch_state_e state,
	output logic         req_fire,
	output logic         resp_fire,
	output logic [1:0]   word_sel
);

	fetch_state_e state_q;
	fetch_state_e state_d;

	// one fill in flight at a time
	assign l15_val   = (state_q == S_REQ) && info.wake_up;
	assign req_fire  = l15_val && header_ack;
	assign resp_fire = info.fill_val && (state_q == S_RESP);

	// non-fetch returns are acked wherever they show up
	assign req_ack = info.other_val || ((state_q == S_RESP) && info.fill_val);

	assign l15_rqtype = RQ_IFILL;
	assign l15_size   = RQ_SIZE_16B;

	// redirects only steer the address while a request can go out
	always_comb
	begin
		if (state_q != S_REQ)
			l15_address = pc;		// hold for the response word select
		else if (!info.wake_up)
			l15_address = RESET_PC;
		else if (exception_pending)
			l15_address = epc;
		else if (pcsel == 2'd2)
			l15_address = target;
		else
			l15_address = pc;
	end

	assign word_sel = l15_address[3:2];

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			S_REQ:
			begin
				if (req_fire)
					state_d = ack ? S_RESP : S_WAIT_ACK;
			end
			S_WAIT_ACK:
			begin
				if (ack)
					state_d = S_RESP;
			end
			S_RESP:
			begin
				if (resp_fire)
					state_d = S_REQ;	// fill ends the fetch
			end
			default: state_d = S_REQ;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			state_q <= S_REQ;
		else
			state_q <= state_d;
	end

	assign state = state_q;

endmodule

// ==== l15_resp_decoder.sv ====
`timescale 1ns/1ps

module l15_resp_decoder
	import fetch_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  l15_resp_s  resp,
	input  logic [1:0] word_sel,
	output resp_info_s info
);

	logic   wake_up_q;
	logic   is_fill;
	logic   is_other;
	instr_t word;	// still in memory byte order

	// core sleeps until the first interrupt return comes back
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wake_up_q <= 1'b0;
		end
		else if (!wake_up_q && resp.val && (resp.rtype == RT_INT_RET))
		begin
			wake_up_q <= 1'b1;	// sticky from here on
		end
	end

	// loads count as fills, the l1.5 may answer an ifill that way
	assign is_fill = (resp.rtype == RT_IFILL_RET) || (resp.rtype == RT_LOAD_RET);

	// invalidations, interrupts and the rest just get acked
	assign is_other = (resp.rtype != RT_LOAD_RET)
		&& (resp.rtype != RT_IFILL_RET)
		&& (resp.rtype != RT_ST_ACK);

	// word order inside the 128-bit line is big endian per half
	always_comb
	begin
		case (word_sel)
			2'd0: word = resp.data_0[63:32];
			2'd1: word = resp.data_0[31:0];
			2'd2: word = resp.data_1[63:32];
			default: word = resp.data_1[31:0];
		endcase
	end

	always_comb
	begin
		info.wake_up   = wake_up_q;
		info.fill_val  = resp.val && is_fill;
		info.other_val = resp.val && is_other;
		// byte swap into instruction order
		info.instr     = {word[7:0], word[15:8], word[23:16], word[31:24]};
	end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_frontend -f all.f &&
./obj_dir/Vtb_fetch_frontend | tee /dev/stderr | grep -q "^No errors$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tb_fetch_frontend.sv ====
`timescale 1ns/1ps

module tb_fetch_frontend
	import fetch_pkg::*;
();

	localparam addr_t BOOT_PC = 32'h4000_0000;	// dut default

	typedef struct
	{
		string      name;
		int         pcsel;
		addr_t      target;
		int         exc;
		addr_t      epc;
		int         stall;
		int         nostall;
		int         killnum;
		int         delay;		// ack delay in cycles
		l15_rtype_t first_rt;	// injected ahead of the fill
		int         late;		// target given during the response phase
		addr_t      exp_addr;
		int         exp_nop;
	} entry_t;

	logic clk;
	logic nrst;
	logic stall;
	logic nostall;
	logic [1:0] killnum;
	logic [1:0] pcsel;
	addr_t target;
	logic exception_pending;
	addr_t epc;
	logic ack;
	logic header_ack;
	logic rsp_val;
	l15_data_t data_0;
	l15_data_t data_1;
	l15_rtype_t rtype;
	logic misaligned2;
	addr_t pc2;
	instr_t instr2;
	logic discardwire;
	logic [4:0] rqtype;
	logic [2:0] rqsize;
	addr_t address;
	l15_data_t wdata;
	logic req_val;
	logic req_ack;
	fetch_state_e state_reg;

	entry_t table_q[$];
	logic [31:0] lfsr;
	logic [127:0] image [logic [27:0]];	// l1.5 model with one entry per line
	addr_t ref_pc;
	logic ref_discard;

	fetch_frontend i_dut (.clk(clk), .nrst(nrst), .stall(stall), .nostall(nostall),
		.killnum(killnum), .pcsel(pcsel), .target(target),
		.exception_pending(exception_pending), .epc(epc),
		.instruction_addr_misaligned2(misaligned2), .pc2(pc2), .instr2(instr2),
		.discardwire(discardwire), .transducer_l15_rqtype(rqtype),
		.transducer_l15_size(rqsize), .transducer_l15_address(address),
		.transducer_l15_data(wdata), .transducer_l15_val(req_val),
		.l15_transducer_ack(ack), .l15_transducer_header_ack(header_ack),
		.l15_transducer_val(rsp_val), .l15_transducer_data_0(data_0),
		.l15_transducer_data_1(data_1), .l15_transducer_returntype(rtype),
		.transducer_l15_req_ack(req_ack), .state_reg(state_reg));

	always #50 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			bits = {bits[30:0], lfsr[0]};	// one step per bit
		end
	endtask

	// lines are filled on first touch
	task automatic line_for(input addr_t a, output logic [127:0] line);
		logic [31:0] w;
		logic [127:0] fresh;
		if (!image.exists(a[31:4]))
		begin
			for (int i = 0; i < 4; i++)
			begin
				take_bits(32, w);
				fresh[127 - 32 * i -: 32] = w;
			end
			image[a[31:4]] = fresh;
		end
		line = image[a[31:4]];
	endtask

	// word 0 sits at the top of data_0 and its bytes come out reversed
	function automatic instr_t expect_instr(input logic [127:0] line, input addr_t a);
		logic [31:0] w;
		w = line[127 - 32 * a[3:2] -: 32];
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	task automatic fail_run();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act)
		else
		begin
			$display("Mismatch in %s, %s: expected %h, actual %h", name, what, exp, act);
			fail_run();
		end
	endtask

	task automatic add_row(input string n, input int ps, input addr_t tg, input int ex,
		input addr_t ep, input int st, input int ns, input int kn, input int dl,
		input l15_rtype_t rt, input int lt, input addr_t ea, input int en);
		entry_t e;
		e = '{n, ps, tg, ex, ep, st, ns, kn, dl, rt, lt, ea, en};
		table_q.push_back(e);
	endtask

	task automatic run_entry(input entry_t e);
		logic [127:0] line;
		logic [31:0] gap;
		logic [31:0] junk;
		addr_t model_addr;
		instr_t exp_i;
		if (e.exc != 0)
			model_addr = e.epc;
		else if (e.pcsel == 2 && e.late == 0)
			model_addr = e.target;
		else
			model_addr = ref_pc;
		pcsel = (e.late == 0) ? e.pcsel[1:0] : 2'd0;
		target = e.target;
		exception_pending = e.exc[0];
		epc = e.epc;
		header_ack = 1'b1;
		ack = (e.delay == 0);
		@(negedge clk);
		while (!req_val)
			@(negedge clk);
		check_value(e.name, "request address", e.exp_addr, address);
		check_value(e.name, "model address", model_addr, address);
		check_value(e.name, "rqtype", 32'd0, 32'(rqtype));	// ifill
		check_value(e.name, "request size", 32'(RQ_SIZE_16B), 32'(rqsize));
		check_value(e.name, "write data high", 32'd0, wdata[63:32]);
		check_value(e.name, "write data low", 32'd0, wdata[31:0]);
		@(posedge clk);
		#5;
		pcsel = 2'd0;
		exception_pending = 1'b0;
		header_ack = 1'b0;
		ack = 1'b0;
		check_value(e.name, "state after request", 32'(e.delay == 0 ? S_RESP : S_WAIT_ACK),
			32'(state_reg));
		if (e.delay > 0)
		begin
			for (int i = 1; i < e.delay; i++)
			begin
				@(posedge clk);
				#5;
			end
			ack = 1'b1;
			@(posedge clk);
			#5;
			ack = 1'b0;
		end
		// a non-fetch return gets acked and dropped
		if (e.first_rt != RT_IFILL_RET)
		begin
			take_bits(32, junk);
			rsp_val = 1'b1;
			rtype = e.first_rt;
			data_0 = {junk, ~junk};
			data_1 = {~junk, junk};
			@(negedge clk);
			check_value(e.name, "req_ack on other return", 32'd1, 32'(req_ack));
			check_value(e.name, "instr2 on other return", NOP_INSTR, instr2);
			@(posedge clk);
			#5;
			rsp_val = 1'b0;
			check_value(e.name, "state after other return", 32'(S_RESP), 32'(state_reg));
		end
		if (e.late != 0)
		begin
			pcsel = e.pcsel[1:0];	// branch lands while the fill is out
			@(posedge clk);
			#5;
			pcsel = 2'd0;
		end
		take_bits(2, gap);
		repeat (gap)
		begin
			@(negedge clk);
			check_value(e.name, "instr2 while waiting", NOP_INSTR, instr2);
			@(posedge clk);
			#5;
		end
		line_for(model_addr, line);
		rsp_val = 1'b1;
		rtype = RT_IFILL_RET;
		data_0 = line[127:64];
		data_1 = line[63:0];
		stall = e.stall[0];
		nostall = e.nostall[0];
		killnum = e.killnum[1:0];
		exp_i = (e.exp_nop != 0) ? NOP_INSTR : expect_instr(line, model_addr);
		@(negedge clk);
		check_value(e.name, "req_ack on fill", 32'd1, 32'(req_ack));
		check_value(e.name, "instr2", exp_i, instr2);
		check_value(e.name, "pc2", model_addr, pc2);
		check_value(e.name, "misaligned2", 32'(model_addr[1:0] == 2'b11), 32'(misaligned2));
		check_value(e.name, "discardwire", 32'(ref_discard), 32'(discardwire));
		@(posedge clk);
		#5;
		rsp_val = 1'b0;
		stall = 1'b0;
		nostall = 1'b0;
		killnum = 2'd0;
		check_value(e.name, "state after fill", 32'(S_REQ), 32'(state_reg));
		if (e.stall != 0 && e.nostall != 0)
		begin
			ref_discard = 1'b1;
			ref_pc = model_addr;	// reload from pc2
		end
		else if (ref_discard)
		begin
			ref_discard = 1'b0;
			ref_pc = model_addr;
		end
		else if (e.stall != 0)
			ref_pc = model_addr;
		else if (e.late != 0)
			ref_pc = e.target;
		else
			ref_pc = model_addr + 32'd4;
	endtask

	initial
	begin
		clk = 1'b0;
		nrst = 1'b0;
		stall = 1'b0;
		nostall = 1'b0;
		killnum = 2'd0;
		pcsel = 2'd0;
		target = '0;
		exception_pending = 1'b0;
		epc = '0;
		ack = 1'b0;
		header_ack = 1'b0;
		rsp_val = 1'b0;
		data_0 = '0;
		data_1 = '0;
		rtype = RT_IFILL_RET;
		lfsr = 32'hd4af8073;
		ref_pc = BOOT_PC;
		ref_discard = 1'b0;
		add_row("reset_pc", 0, 0, 0, 0, 0, 0, 0, 0, RT_IFILL_RET, 0, 32'h40000000, 0);
		add_row("seq_wait2", 0, 0, 0, 0, 0, 0, 0, 2, RT_IFILL_RET, 0, 32'h40000004, 0);
		add_row("seq_direct", 0, 0, 0, 0, 0, 0, 0, 0, RT_IFILL_RET, 0, 32'h40000008, 0);
		add_row("seq_wait1", 0, 0, 0, 0, 0, 0, 0, 1, RT_IFILL_RET, 0, 32'h4000000c, 0);
		add_row("seq_wait3", 0, 0, 0, 0, 0, 0, 0, 3, RT_IFILL_RET, 0, 32'h40000010, 0);
		add_row("br_req", 2, 32'h40000124, 0, 0, 0, 0, 0, 0, RT_IFILL_RET, 0, 32'h40000124, 0);
		add_row("br_late", 2, 32'h40000200, 0, 0, 0, 0, 0, 1, RT_IFILL_RET, 1, 32'h40000128, 0);
		add_row("br_taken", 0, 0, 0, 0, 0, 0, 0, 0, RT_IFILL_RET, 0, 32'h40000200, 0);
		add_row("exc", 0, 0, 1, 32'h40000340, 0, 0, 0, 2, RT_IFILL_RET, 0, 32'h40000340, 0);
		add_row("after_epc", 0, 0, 0, 0, 0, 0, 0, 0, RT_IFILL_RET, 0, 32'h40000344, 0);
		add_row("stall", 0, 0, 0, 0, 1, 0, 0, 0, RT_IFILL_RET, 0, 32'h40000348, 1);
		add_row("stall_refetch", 0, 0, 0, 0, 0, 0, 0, 1, RT_IFILL_RET, 0, 32'h40000348, 0);
		add_row("kill", 0, 0, 0, 0, 0, 0, 1, 0, RT_IFILL_RET, 0, 32'h4000034c, 1);
		add_row("discard", 0, 0, 0, 0, 1, 1, 0, 0, RT_IFILL_RET, 0, 32'h40000350, 1);
		add_row("discard_drop", 0, 0, 0, 0, 0, 0, 0, 2, RT_IFILL_RET, 0, 32'h40000350, 1);
		add_row("refetch", 0, 0, 0, 0, 0, 0, 0, 0, RT_IFILL_RET, 0, 32'h40000350, 0);
		add_row("inv_ignored", 0, 0, 0, 0, 0, 0, 0, 1, RT_INV_RET, 0, 32'h40000354, 0);
		add_row("mis_epc", 0, 0, 1, 32'h40000463, 0, 0, 0, 0, RT_IFILL_RET, 0, 32'h40000463, 0);
		add_row("realign", 2, 32'h40000500, 0, 0, 0, 0, 0, 0, RT_IFILL_RET, 0, 32'h40000500, 0);
		add_row("seq_end", 0, 0, 0, 0, 0, 0, 0, 3, RT_IFILL_RET, 0, 32'h40000504, 0);
		repeat (4) @(posedge clk);
		#5;
		nrst = 1'b1;
		// nothing may go out while the core sleeps
		repeat (3)
		begin
			@(negedge clk);
			check_value("sleep", "request valid", 32'd0, 32'(req_val));
			check_value("sleep", "instr2", NOP_INSTR, instr2);
			@(posedge clk);
			#5;
		end
		rsp_val = 1'b1;
		rtype = RT_INT_RET;
		@(negedge clk);
		check_value("wake_up", "req_ack", 32'd1, 32'(req_ack));
		check_value("wake_up", "request valid", 32'd0, 32'(req_val));
		@(posedge clk);
		#5;
		rsp_val = 1'b0;
		foreach (table_q[i])
			run_entry(table_q[i]);
		// discard level must be clear after the last fill
		check_value("end", "discardwire", 32'(ref_discard), 32'(discardwire));
		$display("No errors");
		$finish;
	end

	// budget of 40 cycles per table entry
	initial
	begin
		#1;
		repeat (table_q.size() * 40) @(posedge clk);
		$display("Fetch hung, the table did not finish within %0d cycles", table_q.size() * 40);
		fail_run();
	end

endmodule
